/* bench/efi_tb.sv */
// ============================================================
// EFI core testbench
// Loads, function calls, busy drops and unknown opcodes,
// checked against a register file model via the debug port
// ============================================================

`timescale 1ns/1ps
`default_nettype none

module efi_tb;

    // The tests run for under 4000 cycles
    localparam int cycle_limit = 20000;
    localparam int done_limit = 40;

    logic clock;
    logic reset;
    efi_pkg::instruction_t instruction;
    logic instruction_valid;
    logic busy;
    logic done;
    logic [5:0] debug_address;
    logic [19:0] debug_data;

    logic [19:0] model [64];
    integer seed = 32'h2adf_2f9b;
    int cycle_count = 0;
    int check_count = 0;
    int error_count = 0;
    int test_errors = 0;
    int tests_run = 0;
    int tests_failed = 0;

    efi_top uut (
        .clock(clock), .reset(reset),
        .instruction(instruction), .instruction_valid(instruction_valid),
        .busy(busy), .done(done),
        .debug_address(debug_address), .debug_data(debug_data)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            error_count = error_count + 1;
            end_run();
        end
    end

    // Load word fields in order are opcode, channel, destination, immediate and pad
    function automatic logic [31:0] load_word(input logic [1:0] channel,
                                              input logic [3:0] destination,
                                              input logic [19:0] immediate);
        return {4'd1, channel, destination, immediate, 2'b00};
    endfunction

    // Call word fields in order are opcode, channel, base, length, result and pad
    function automatic logic [31:0] call_word(input logic [1:0] channel, input logic [3:0] base,
                                              input logic [3:0] length, input logic [3:0] result);
        return {4'd2, channel, base, length, result, 14'd0};
    endfunction

    // Wrapping sum and signed maximum over length+1 registers whose index wraps in the bank
    function automatic logic [39:0] reference_call(input logic [1:0] channel,
                                                   input logic [3:0] base,
                                                   input logic [3:0] length);
        logic [3:0] index;
        logic [19:0] value;
        logic [19:0] sum;
        logic [19:0] maximum;
        index = base;
        sum = '0;
        maximum = model[{channel, base}];
        for (int i = 0; i <= int'(length); i++) begin
            value = model[{channel, index}];
            sum = sum + value;
            if ($signed(value) > $signed(maximum)) begin
                maximum = value;
            end
            index = index + 4'd1;
        end
        return {sum, maximum};
    endfunction

    task automatic check_value(input string label, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count = check_count + 1;
        if (expected !== actual) begin
            error_count = error_count + 1;
            test_errors = test_errors + 1;
            $display("error %s: expected %h, actual %h", label, expected, actual);
        end
    endtask

    task automatic finish_test(input string name);
        tests_run = tests_run + 1;
        if (test_errors == 0) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed = tests_failed + 1;
            $display("test %s: %0d mismatches", name, test_errors);
        end
        test_errors = 0;
    endtask

    task automatic end_run();
        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, check_count, error_count);
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    endtask

    task automatic issue(input logic [31:0] word);
        @(posedge clock);
        instruction <= word;
        instruction_valid <= 1'b1;
        @(posedge clock);
        instruction_valid <= 1'b0;
    endtask

    task automatic check_registers(input string name);
        for (int a = 0; a < 64; a++) begin
            @(posedge clock);
            debug_address <= a[5:0];
            @(negedge clock);
            check_value($sformatf("%s register %0d", name, a), 32'(model[a]), 32'(debug_data));
        end
    endtask

    task automatic wait_call(input string name);
        int waited;
        logic seen_busy;
        waited = 0;
        seen_busy = 1'b0;
        do begin
            @(negedge clock);
            waited = waited + 1;
            if (busy) begin
                seen_busy = 1'b1;
            end
        end while (!done && waited < done_limit);
        if (!done) begin
            $display("timeout: done did not arrive within %0d cycles of a call in test %s",
                     done_limit, name);
            error_count = error_count + 1;
            end_run();
        end else begin
            check_value({name, " busy during call"}, 32'd1, 32'(seen_busy));
            @(negedge clock);
            check_value({name, " done pulse width"}, 32'd0, 32'(done));
            check_value({name, " busy after done"}, 32'd0, 32'(busy));
        end
    endtask

    // A load strobed mid-call must be dropped, so the model ignores it
    task automatic run_call(input string name, input logic [1:0] channel, input logic [3:0] base,
                            input logic [3:0] length, input logic [3:0] result, input bit intrude);
        logic [39:0] expected;
        logic [31:0] r;
        expected = reference_call(channel, base, length);
        issue(call_word(channel, base, length, result));
        if (intrude) begin
            @(negedge clock);
            @(negedge clock);
            r = $random(seed);
            issue(load_word(r[31:30], r[29:26], r[19:0]));
        end
        wait_call(name);
        model[{channel, result}] = expected[39:20];
        model[{channel, result + 4'd1}] = expected[19:0];
        check_registers(name);
    endtask

    task automatic test_loads();
        logic [31:0] r;
        for (int a = 0; a < 64; a++) begin
            r = $random(seed);
            model[a] = r[19:0];
            issue(load_word(a[5:4], a[3:0], r[19:0]));
        end
        check_registers("loads");
        finish_test("loads");
    endtask

    task automatic test_calls();
        logic [31:0] r;
        run_call("calls length 0", 2'd1, 4'd5, 4'd0, 4'd9, 1'b0);
        run_call("calls wrapped", 2'd3, 4'd13, 4'd6, 4'd2, 1'b0);
        for (int n = 0; n < 30; n++) begin
            r = $random(seed);
            run_call("calls random", r[1:0], r[5:2], r[9:6], r[13:10], 1'b0);
        end
        finish_test("calls");
    endtask

    task automatic test_busy_drop();
        logic [31:0] r;
        for (int n = 0; n < 4; n++) begin
            r = $random(seed);
            run_call("busy drop", r[1:0], r[5:2], r[9:6], r[13:10], 1'b1);
        end
        finish_test("busy drop");
    endtask

    task automatic test_unknown_opcodes();
        logic [31:0] r;
        for (int op = 0; op < 16; op++) begin
            if (op != 1 && op != 2) begin
                r = $random(seed);
                issue({op[3:0], r[27:0]});
                repeat (4) begin
                    @(negedge clock);
                    check_value("unknown opcodes busy", 32'd0, 32'(busy));
                end
            end
        end
        check_registers("unknown opcodes");
        finish_test("unknown opcodes");
    endtask

    initial begin
        reset = 1'b0;
        instruction = '0;
        instruction_valid = 1'b0;
        debug_address = '0;
        for (int a = 0; a < 64; a++) begin
            model[a] = '0;
        end
        repeat (8) @(posedge clock);
        reset <= 1'b1;
        @(negedge clock);
        check_value("reset busy", 32'd0, 32'(busy));
        check_value("reset done", 32'd0, 32'(done));
        check_registers("reset");
        finish_test("reset");
        test_loads();
        test_calls();
        test_busy_drop();
        test_unknown_opcodes();
        end_run();
    end

endmodule

`default_nettype wire

/* common/efi_pkg.sv */
// ==========================================================
// EFI core package
// Sizes, opcodes, FSM encodings and the instruction word
// layout shared by every block of the EFI core
// ==========================================================

`default_nettype none

package efi_pkg;

    localparam int data_width = 20;
    localparam int reg_addr_width = 4;
    localparam int channel_width = 2;
    localparam int full_addr_width = channel_width + reg_addr_width;
    localparam int length_width = 4;
    localparam int instr_width = 32;
    localparam int opcode_width = 4;

    localparam logic [opcode_width-1:0] op_load = 4'd1;
    localparam logic [opcode_width-1:0] op_efi = 4'd2;

    // The function unit returns the sum first, then the maximum
    localparam int result_count = 2;

    // Memory handler FSM encoding
    localparam int handler_state_width = 2;
    localparam logic [handler_state_width-1:0] handler_idle = 2'd0;
    localparam logic [handler_state_width-1:0] handler_send = 2'd1;
    localparam logic [handler_state_width-1:0] handler_finish = 2'd2;

    localparam int load_pad_width =
        instr_width - opcode_width - channel_width - reg_addr_width - data_width;
    localparam int call_pad_width =
        instr_width - opcode_width - channel_width - 3 * reg_addr_width;

    // Both views keep the opcode in the top nibble
    typedef union packed {
        struct packed {
            logic [opcode_width-1:0] opcode;
            logic [channel_width-1:0] channel;
            logic [reg_addr_width-1:0] destination;
            logic [data_width-1:0] immediate;
            logic [load_pad_width-1:0] pad;
        } load_view;
        struct packed {
            logic [opcode_width-1:0] opcode;
            logic [channel_width-1:0] channel;
            logic [reg_addr_width-1:0] base;
            logic [length_width-1:0] length;
            logic [reg_addr_width-1:0] result;
            logic [call_pad_width-1:0] pad;
        } call_view;
    } instruction_t;

endpackage

`default_nettype wire

/* efi_handler/efi_memory_handler.sv */
// ==========================================================
// EFI memory handler
// Walks a run of argument registers in one channel bank and
// streams the words to the function unit, one per cycle
// ==========================================================

`timescale 1ns/1ps
`default_nettype none

module efi_memory_handler (
    input wire clock,
    input wire reset,
    input wire call_start,
    input wire [efi_pkg::channel_width-1:0] call_channel,
    input wire [efi_pkg::reg_addr_width-1:0] call_base,
    input wire [efi_pkg::length_width-1:0] call_length,
    input wire [efi_pkg::data_width-1:0] argument_data,
    output logic [efi_pkg::full_addr_width-1:0] argument_address,
    output logic [efi_pkg::data_width-1:0] stream_data,
    output logic stream_valid,
    output logic stream_last
);

    logic [efi_pkg::handler_state_width-1:0] state;
    logic [efi_pkg::reg_addr_width-1:0] register_index;
    logic [efi_pkg::length_width-1:0] argument_count;
    logic final_argument;

    // The decoder holds the call fields for the whole call, so only the
    // running index and count live here
    assign argument_address = {call_channel, register_index};
    assign final_argument = (argument_count == call_length);

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state <= efi_pkg::handler_idle;
            register_index <= '0;
            argument_count <= '0;
            stream_valid <= 1'b0;
            stream_last <= 1'b0;
        end else begin
            case (state)
                efi_pkg::handler_idle: begin
                    stream_valid <= 1'b0;
                    stream_last <= 1'b0;
                    if (call_start) begin
                        register_index <= call_base;
                        argument_count <= '0;
                        state <= efi_pkg::handler_send;
                    end
                end
                efi_pkg::handler_send: begin
                    stream_valid <= 1'b1;
                    stream_last <= final_argument;
                    if (final_argument) begin
                        state <= efi_pkg::handler_finish;
                    end else begin
                        // Index wraps inside the bank, the channel bits stay put
                        register_index <= register_index + 1'b1;
                        argument_count <= argument_count + 1'b1;
                    end
                end
                efi_pkg::handler_finish: begin
                    stream_valid <= 1'b0;
                    stream_last <= 1'b0;
                    state <= efi_pkg::handler_idle;
                end
                default: begin
                    stream_valid <= 1'b0;
                    stream_last <= 1'b0;
                    state <= efi_pkg::handler_idle;
                end
            endcase
        end
    end

    // Registered copy of each word read while sending
    always_ff @(posedge clock) begin
        if (state == efi_pkg::handler_send) begin
            stream_data <= argument_data;
        end
    end

endmodule

`default_nettype wire

/* flist.f */
common/efi_pkg.sv
hw/efi_decoder.sv
hw/register_file.sv
efi_handler/efi_memory_handler.sv
hw/efi_function_unit.sv
hw/efi_result_writer.sv
hw/efi_top.sv
bench/efi_tb.sv

/* hw/efi_decoder.sv */
// ==========================================================
// EFI instruction decoder
// Turns load words into register writes and call words into
// a start pulse, and tracks the busy state of the core
// ==========================================================

`timescale 1ns/1ps
`default_nettype none

module efi_decoder (
    input wire clock,
    input wire reset,
    input wire efi_pkg::instruction_t instruction,
    input wire instruction_valid,
    input wire done,
    output logic busy,
    output logic load_enable,
    output logic [efi_pkg::full_addr_width-1:0] load_address,
    output logic [efi_pkg::data_width-1:0] load_data,
    output logic call_start,
    output logic [efi_pkg::channel_width-1:0] call_channel,
    output logic [efi_pkg::reg_addr_width-1:0] call_base,
    output logic [efi_pkg::length_width-1:0] call_length,
    output logic [efi_pkg::reg_addr_width-1:0] call_result
);

    logic accept;
    logic is_load;
    logic is_call;

    // The cycle of call_start already counts as busy, since busy only rises one edge later
    assign accept = instruction_valid && !busy && !call_start;
    assign is_load = accept && (instruction.load_view.opcode == efi_pkg::op_load);
    assign is_call = accept && (instruction.call_view.opcode == efi_pkg::op_efi);

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            load_enable <= 1'b0;
            call_start <= 1'b0;
            busy <= 1'b0;
        end else begin
            load_enable <= is_load;
            call_start <= is_call;
            if (call_start) begin
                busy <= 1'b1;
            end else if (done) begin
                busy <= 1'b0;
            end
        end
    end

    // Payload fields, held until the next accepted instruction of the same kind
    always_ff @(posedge clock) begin
        if (is_load) begin
            load_address <= {instruction.load_view.channel, instruction.load_view.destination};
            load_data <= instruction.load_view.immediate;
        end
        if (is_call) begin
            call_channel <= instruction.call_view.channel;
            call_base <= instruction.call_view.base;
            call_length <= instruction.call_view.length;
            call_result <= instruction.call_view.result;
        end
    end

endmodule

`default_nettype wire

/* hw/efi_function_unit.sv */
// ==========================================================
// EFI function unit
// Folds the argument stream into a wrapping sum and a signed
// maximum, then returns the sum followed by the maximum
// ==========================================================

`timescale 1ns/1ps
`default_nettype none

module efi_function_unit (
    input wire clock,
    input wire reset,
    input wire [efi_pkg::data_width-1:0] stream_data,
    input wire stream_valid,
    input wire stream_last,
    output logic [efi_pkg::data_width-1:0] result_data,
    output logic result_valid
);

    logic first_argument;
    logic emit_maximum;
    logic [efi_pkg::data_width-1:0] sum;
    logic [efi_pkg::data_width-1:0] maximum;
    logic [efi_pkg::data_width-1:0] sum_next;
    logic [efi_pkg::data_width-1:0] maximum_next;

    // The first argument seeds both accumulators
    always_comb begin
        if (first_argument) begin
            sum_next = stream_data;
            maximum_next = stream_data;
        end else begin
            sum_next = sum + stream_data;
            if ($signed(stream_data) > $signed(maximum)) begin
                maximum_next = stream_data;
            end else begin
                maximum_next = maximum;
            end
        end
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            first_argument <= 1'b1;
            emit_maximum <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            if (stream_valid) begin
                first_argument <= stream_last;
            end
            emit_maximum <= stream_valid && stream_last;
            result_valid <= (stream_valid && stream_last) || emit_maximum;
        end
    end

    always_ff @(posedge clock) begin
        if (stream_valid) begin
            sum <= sum_next;
            maximum <= maximum_next;
        end
        if (stream_valid && stream_last) begin
            result_data <= sum_next;
        end else if (emit_maximum) begin
            result_data <= maximum;
        end
    end

endmodule

`default_nettype wire

/* hw/efi_result_writer.sv */
// ==========================================================
// EFI result writer
// Stores the returned results in consecutive registers of the
// call's bank and pulses done after the last one
// ==========================================================

`timescale 1ns/1ps
`default_nettype none

module efi_result_writer (
    input wire clock,
    input wire reset,
    input wire call_start,
    input wire [efi_pkg::channel_width-1:0] call_channel,
    input wire [efi_pkg::reg_addr_width-1:0] call_result,
    input wire [efi_pkg::data_width-1:0] result_data,
    input wire result_valid,
    output logic result_enable,
    output logic [efi_pkg::full_addr_width-1:0] result_address,
    output logic [efi_pkg::data_width-1:0] result_write_data,
    output logic done
);

    logic [efi_pkg::reg_addr_width-1:0] destination_index;
    logic [$clog2(efi_pkg::result_count)-1:0] result_index;
    logic last_result;

    // Each result is written in the cycle it arrives
    assign result_enable = result_valid;
    assign result_address = {call_channel, destination_index};
    assign result_write_data = result_data;
    assign last_result = (result_index == efi_pkg::result_count - 1);

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            destination_index <= '0;
            result_index <= '0;
            done <= 1'b0;
        end else begin
            done <= result_valid && last_result;
            if (call_start) begin
                destination_index <= call_result;
                result_index <= '0;
            end else if (result_valid) begin
                // Wraps within the bank like the argument range does
                destination_index <= destination_index + 1'b1;
                result_index <= result_index + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/efi_top.sv */
// ==========================================================
// EFI core top level
// Decoder, banked register file, memory handler, function
// unit and result writer, with a debug read port
// ==========================================================

`timescale 1ns/1ps
`default_nettype none

module efi_top (
    input wire clock,
    input wire reset,
    input wire efi_pkg::instruction_t instruction,
    input wire instruction_valid,
    output logic busy,
    output logic done,
    input wire [efi_pkg::full_addr_width-1:0] debug_address,
    output logic [efi_pkg::data_width-1:0] debug_data
);

    logic load_enable;
    logic [efi_pkg::full_addr_width-1:0] load_address;
    logic [efi_pkg::data_width-1:0] load_data;
    logic call_start;
    logic [efi_pkg::channel_width-1:0] call_channel;
    logic [efi_pkg::reg_addr_width-1:0] call_base;
    logic [efi_pkg::length_width-1:0] call_length;
    logic [efi_pkg::reg_addr_width-1:0] call_result;
    logic [efi_pkg::full_addr_width-1:0] argument_address;
    logic [efi_pkg::data_width-1:0] argument_data;
    logic [efi_pkg::data_width-1:0] stream_data;
    logic stream_valid;
    logic stream_last;
    logic [efi_pkg::data_width-1:0] result_data;
    logic result_valid;
    logic result_enable;
    logic [efi_pkg::full_addr_width-1:0] result_address;
    logic [efi_pkg::data_width-1:0] result_write_data;

    efi_decoder decoder (
        .clock(clock), .reset(reset),
        .instruction(instruction), .instruction_valid(instruction_valid),
        .done(done), .busy(busy),
        .load_enable(load_enable), .load_address(load_address), .load_data(load_data),
        .call_start(call_start), .call_channel(call_channel), .call_base(call_base),
        .call_length(call_length), .call_result(call_result)
    );

    register_file registers (
        .clock(clock), .reset(reset),
        .load_enable(load_enable), .load_address(load_address), .load_data(load_data),
        .result_enable(result_enable), .result_address(result_address),
        .result_data(result_write_data),
        .argument_address(argument_address), .debug_address(debug_address),
        .argument_data(argument_data), .debug_data(debug_data)
    );

    efi_memory_handler handler (
        .clock(clock), .reset(reset),
        .call_start(call_start), .call_channel(call_channel), .call_base(call_base),
        .call_length(call_length), .argument_data(argument_data),
        .argument_address(argument_address), .stream_data(stream_data),
        .stream_valid(stream_valid), .stream_last(stream_last)
    );

    efi_function_unit function_unit (
        .clock(clock), .reset(reset),
        .stream_data(stream_data), .stream_valid(stream_valid), .stream_last(stream_last),
        .result_data(result_data), .result_valid(result_valid)
    );

    efi_result_writer writer (
        .clock(clock), .reset(reset),
        .call_start(call_start), .call_channel(call_channel), .call_result(call_result),
        .result_data(result_data), .result_valid(result_valid),
        .result_enable(result_enable), .result_address(result_address),
        .result_write_data(result_write_data), .done(done)
    );

endmodule

`default_nettype wire

/* hw/register_file.sv */
// ==========================================================
// Channel-banked register file
// 64 words in four banks of 16, one load and one result write
// port, combinational argument and debug reads
// ==========================================================

`timescale 1ns/1ps
`default_nettype none

module register_file (
    input wire clock,
    input wire reset,
    input wire load_enable,
    input wire [efi_pkg::full_addr_width-1:0] load_address,
    input wire [efi_pkg::data_width-1:0] load_data,
    input wire result_enable,
    input wire [efi_pkg::full_addr_width-1:0] result_address,
    input wire [efi_pkg::data_width-1:0] result_data,
    input wire [efi_pkg::full_addr_width-1:0] argument_address,
    input wire [efi_pkg::full_addr_width-1:0] debug_address,
    output logic [efi_pkg::data_width-1:0] argument_data,
    output logic [efi_pkg::data_width-1:0] debug_data
);

    localparam int depth = 2 ** efi_pkg::full_addr_width;

    logic [efi_pkg::data_width-1:0] registers [depth];

    // Loads happen only while idle and result writes only during a call,
    // so the two ports never hit the array in the same cycle
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < depth; i++) begin
                registers[i] <= '0;
            end
        end else begin
            if (load_enable) begin
                registers[load_address] <= load_data;
            end
            if (result_enable) begin
                registers[result_address] <= result_data;
            end
        end
    end

    assign argument_data = registers[argument_address];
    assign debug_data = registers[debug_address];

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build and run the EFI core testbench with Verilator
log=sim.log

verilator --binary --timing -Wno-fatal -f flist.f --top-module efi_tb -o efi_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/efi_sim > "$log" 2>&1
if [ $? -ne 0 ]; then
    cat "$log"
    echo "simulation did not run to completion"
    exit 1
fi
cat "$log"

if grep -q "All tests passed!" "$log"; then
    exit 0
fi
exit 1
